/* verilog/pow_consts.svh */
`ifndef POW_CONSTS_SVH
`define POW_CONSTS_SVH

// --------------------------------------------------
// Datapath sizing
// --------------------------------------------------

// Switch operand width
`define POW_OPERAND_W 8

// Multiply stages from square to fifth power
`define POW_STAGES 4

// --------------------------------------------------
// Display sizing
// --------------------------------------------------

`define DISP_DIGITS 8

// Prescaler width, one digit step per wrap
`define DISP_SCAN_W 4

`endif

/* verilog/pow_types_pkg.sv */
package pow_types_pkg;

    `include "pow_consts.svh"

    // --------------------------------------------------
    // Pipeline data types
    // --------------------------------------------------

    // Operand as read from the switches
    typedef logic [`POW_OPERAND_W-1:0] operand_t;

    // Fifth power, wide enough to be exact
    typedef logic [5*`POW_OPERAND_W-1:0] result_t;

    // Input flag, stage flags, output flag (lowest first)
    typedef logic [`POW_STAGES:0] stage_valid_t;

    // Final result with its flag
    typedef struct packed {
        logic    valid;
        result_t value;
    } pow_result_s;

endpackage

/* verilog/display_types_pkg.sv */
package display_types_pkg;

    `include "pow_consts.svh"

    // --------------------------------------------------
    // Seven-segment display types
    // --------------------------------------------------

    typedef logic [3:0] nibble_t;

    // Segments a..g then dot, a in the top bit
    typedef logic [7:0] seg_t;

    // One enable per digit, low means lit
    typedef logic [`DISP_DIGITS-1:0] digit_sel_t;

    // Hex number spread across all digits
    typedef logic [4*`DISP_DIGITS-1:0] display_num_t;

    typedef struct packed {
        seg_t       abcdefgh;
        digit_sel_t digit;
    } seg_drive_s;

endpackage

/* verilog/pow5_pipeline.sv */
`timescale 1ns/1ps

`include "pow_consts.svh"

module pow5_pipeline
    import pow_types_pkg::*;
(
    input  logic         slow_clk,
    input  logic         rst,
    input  logic         load,
    input  operand_t     operand,
    output stage_valid_t stage_valid,
    output pow_result_s  result
);

    localparam int op_w = `POW_OPERAND_W;

    // Bit position of the output flag
    localparam int out_bit = `POW_STAGES;

    // --------------------------------------------------
    // Valid chain
    // --------------------------------------------------

    stage_valid_t valid_q;

    // Shift in the load strobe every cycle
    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[out_bit-1:0], load};
        end
    end

    assign stage_valid = valid_q;

    // --------------------------------------------------
    // Data registers
    // --------------------------------------------------

    operand_t            operand_q;
    operand_t            op_s1;
    operand_t            op_s2;
    operand_t            op_s3;
    logic [2*op_w-1:0]   square_q;
    logic [3*op_w-1:0]   cube_q;
    logic [4*op_w-1:0]   fourth_q;
    result_t             result_q;

    // Operand capture on the load strobe
    always_ff @(posedge slow_clk) begin
        if (load) begin
            operand_q <= operand;
        end
    end

    // Square
    always_ff @(posedge slow_clk) begin
        if (valid_q[0]) begin
            square_q <= operand_q * operand_q;
            op_s1    <= operand_q;
        end
    end

    // Cube
    always_ff @(posedge slow_clk) begin
        if (valid_q[1]) begin
            cube_q <= square_q * op_s1;
            op_s2  <= op_s1;
        end
    end

    // Fourth power
    always_ff @(posedge slow_clk) begin
        if (valid_q[2]) begin
            fourth_q <= cube_q * op_s2;
            op_s3    <= op_s2;
        end
    end

    // Fifth power, held until the next item arrives
    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            result_q <= '0;
        end else if (valid_q[3]) begin
            result_q <= fourth_q * op_s3;
        end
    end

    assign result.valid = valid_q[out_bit];
    assign result.value = result_q;

    // --------------------------------------------------
    // Assertions
    // --------------------------------------------------

    // Fixed five cycle latency from strobe to output flag
    a_latency: assert property (
        @(posedge slow_clk) disable iff (rst)
        1'b1 ##5 1'b1 |-> (result.valid == $past(load, 5))
    );

    a_result_known: assert property (
        @(posedge slow_clk) disable iff (rst)
        result.valid |-> !$isunknown(result.value)
    );

endmodule

/* verilog/seven_segment_display.sv */
`timescale 1ns/1ps

`include "pow_consts.svh"

module seven_segment_display
    import display_types_pkg::*;
(
    input  logic         slow_clk,
    input  logic         rst,
    input  display_num_t number,
    output seg_drive_s   drive
);

    localparam int idx_w = $clog2(`DISP_DIGITS);

    // --------------------------------------------------
    // Hex decoder
    // --------------------------------------------------

    function automatic seg_t hex_to_seg(input nibble_t value);
        seg_t pattern;
        case (value)
            4'h0: pattern = 8'b1111_1100;
            4'h1: pattern = 8'b0110_0000;
            4'h2: pattern = 8'b1101_1010;
            4'h3: pattern = 8'b1111_0010;
            4'h4: pattern = 8'b0110_0110;
            4'h5: pattern = 8'b1011_0110;
            4'h6: pattern = 8'b1011_1110;
            4'h7: pattern = 8'b1110_0000;
            4'h8: pattern = 8'b1111_1110;
            4'h9: pattern = 8'b1111_0110;
            4'ha: pattern = 8'b1110_1110;
            4'hb: pattern = 8'b0011_1110;
            4'hc: pattern = 8'b1001_1100;
            4'hd: pattern = 8'b0111_1010;
            4'he: pattern = 8'b1001_1110;
            default: pattern = 8'b1000_1110;
        endcase
        return pattern;
    endfunction

    // --------------------------------------------------
    // Scan control
    // --------------------------------------------------

    logic [`DISP_SCAN_W-1:0] prescaler;
    logic [idx_w-1:0]        scan_idx;
    logic                    scan_tick;

    // Step to the next digit when the prescaler wraps
    assign scan_tick = &prescaler;

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            prescaler <= '0;
            scan_idx  <= '0;
        end else begin
            prescaler <= prescaler + 1'b1;
            if (scan_tick) begin
                if (scan_idx == idx_w'(`DISP_DIGITS - 1)) begin
                    scan_idx <= '0;
                end else begin
                    scan_idx <= scan_idx + 1'b1;
                end
            end
        end
    end

    // --------------------------------------------------
    // Output drive
    // --------------------------------------------------

    nibble_t cur_nibble;

    assign cur_nibble = number[scan_idx*4 +: 4];

    // Registered segments and active-low digit enable
    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            drive.abcdefgh <= hex_to_seg(4'h0);
            drive.digit    <= ~digit_sel_t'(1);
        end else begin
            drive.abcdefgh <= hex_to_seg(cur_nibble);
            drive.digit    <= ~(digit_sel_t'(1) << scan_idx);
        end
    end

    // One digit lit at a time
    a_one_digit: assert property (
        @(posedge slow_clk) disable iff (rst)
        $countones(~drive.digit) == 1
    );

endmodule

/* verilog/board_top.sv */
`timescale 1ns/1ps

module board_top
    import pow_types_pkg::*;
    import display_types_pkg::*;
(
    input  logic       slow_clk,
    input  logic       rst,

    // Keys, switches and LEDs
    input  logic [3:0] key,
    input  operand_t   sw,
    output logic [7:0] led,

    // Multiplexed seven-segment display
    output seg_t       abcdefgh,
    output digit_sel_t digit
);

    stage_valid_t stage_valid;
    pow_result_s  result;
    seg_drive_s   drive;

    // --------------------------------------------------
    // Fifth power pipeline
    // --------------------------------------------------

    // Key 0 acts as the load strobe
    pow5_pipeline pow_i (
        .slow_clk    (slow_clk),
        .rst         (rst),
        .load        (key[0]),
        .operand     (sw),
        .stage_valid (stage_valid),
        .result      (result)
    );

    // Stage flags on the low LEDs, rest dark
    assign led = {{(8 - $bits(stage_valid_t)){1'b0}}, stage_valid};

    // --------------------------------------------------
    // Display
    // --------------------------------------------------

    // Only the low 32 bits of the result fit
    seven_segment_display disp_i (
        .slow_clk (slow_clk),
        .rst      (rst),
        .number   (result.value[$bits(display_num_t)-1:0]),
        .drive    (drive)
    );

    assign abcdefgh = drive.abcdefgh;
    assign digit    = drive.digit;

endmodule

/* sim/tb_board_top.sv */
`timescale 1ns/1ps

module tb_board_top
    import pow_types_pkg::*;
    import display_types_pkg::*;
();

    // Reset, edge idle, single loads, bursts, four held scans, tail
    localparam int planned_cycles = 8 + 10 + 8 * 9 + 20 * (8 + 3) + 4 * 141 + 10;
    localparam int timeout_cycles = planned_cycles * 3 / 2;

    // Standard hex table, abcdefgh with a in the top bit
    localparam seg_t hex_table [16] = '{
        8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
        8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e
    };

    logic       slow_clk = 1'b0;
    logic       rst;
    logic [3:0] key;
    operand_t   sw;
    logic [7:0] led;
    seg_t       abcdefgh;
    digit_sel_t digit;

    logic [31:0] rng_state;
    int          cycle_count = 0;

    board_top dut_i (
        .slow_clk (slow_clk),
        .rst      (rst),
        .key      (key),
        .sw       (sw),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    always #4 slow_clk = ~slow_clk;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic result_t fifth_power(input operand_t x);
        result_t acc;
        acc = 40'd1;
        repeat (5) acc = acc * x;
        return acc;
    endfunction

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [39:0] expected,
                                   input logic [39:0] actual);
        $display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
        stop_run();
    endtask

    // One clock of stimulus, inputs change 1 ns after the edge
    task automatic drive_cycle(input logic load, input operand_t op);
        key = {3'b000, load};
        sw  = op;
        @(posedge slow_clk);
        #1;
    endtask

    // Load low, switches still moving
    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, operand_t'(next_random()));
    endtask

    task automatic load_and_scan(input operand_t op);
        drive_cycle(1'b1, op);
        idle_cycles(140);
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    stage_valid_t load_hist;
    operand_t     op_hist [4];
    result_t      exp_result;
    logic [6:0]   scan_count;
    digit_sel_t   exp_digit;
    seg_t         exp_seg;

    always @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            load_hist  <= '0;
            op_hist    <= '{default: '0};
            exp_result <= '0;
            scan_count <= '0;
            exp_digit  <= 8'hfe;
            exp_seg    <= hex_table[0];
        end else begin
            load_hist  <= {load_hist[3:0], key[0]};
            op_hist[0] <= sw;
            op_hist[1] <= op_hist[0];
            op_hist[2] <= op_hist[1];
            op_hist[3] <= op_hist[2];
            if (load_hist[3]) begin
                exp_result <= fifth_power(op_hist[3]);
            end
            // Digit index is the top three bits of a 128 cycle scan
            scan_count <= scan_count + 1'b1;
            exp_digit  <= ~(8'b1 << scan_count[6:4]);
            exp_seg    <= hex_table[exp_result[scan_count[6:4] * 4 +: 4]];
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    a_reset_led: assert property (@(posedge slow_clk) (rst && cycle_count > 1) |-> led == 8'h00)
        else report_mismatch("led", 40'h0, $sampled(led));

    a_reset_digit: assert property (@(posedge slow_clk) (rst && cycle_count > 1) |-> digit == 8'hfe)
        else report_mismatch("digit", 40'hfe, $sampled(digit));

    a_reset_result: assert property (
        @(posedge slow_clk) (rst && cycle_count > 1) |-> dut_i.result.value == '0
    ) else report_mismatch("result", 40'h0, $sampled(dut_i.result.value));

    a_leds: assert property (
        @(posedge slow_clk) disable iff (rst) led == {3'b000, load_hist}
    ) else report_mismatch("led", $sampled({3'b000, load_hist}), $sampled(led));

    a_result: assert property (
        @(posedge slow_clk) disable iff (rst) dut_i.result.value == exp_result
    ) else report_mismatch("result", $sampled(exp_result), $sampled(dut_i.result.value));

    a_digit: assert property (@(posedge slow_clk) disable iff (rst) digit == exp_digit)
        else report_mismatch("digit", $sampled(exp_digit), $sampled(digit));

    a_segments: assert property (@(posedge slow_clk) disable iff (rst) abcdefgh == exp_seg)
        else report_mismatch("abcdefgh", $sampled(exp_seg), $sampled(abcdefgh));

    // Run limit
    always @(posedge slow_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            stop_run();
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------

    initial begin
        int run_len;
        rng_state = 32'h60bc9327;
        key = 4'h0;
        sw  = '0;
        rst = 1'b1;
        repeat (8) @(posedge slow_clk);
        #1;
        rst = 1'b0;
        idle_cycles(10);

        // Isolated loads
        repeat (8) begin
            drive_cycle(1'b1, operand_t'(next_random()));
            idle_cycles(8);
        end

        // Bursts of back-to-back loads
        repeat (20) begin
            run_len = 1 + int'(next_random() % 8);
            repeat (run_len) drive_cycle(1'b1, operand_t'(next_random()));
            idle_cycles(int'(next_random() % 4));
        end

        // Edge operands, then a random one, each held through a full scan
        load_and_scan(8'd0);
        load_and_scan(8'd1);
        load_and_scan(8'd255);
        load_and_scan(operand_t'(next_random()));

        idle_cycles(10);
        $display("Regression passed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+verilog
verilog/pow_types_pkg.sv
verilog/display_types_pkg.sv
verilog/pow5_pipeline.sv
verilog/seven_segment_display.sv
verilog/board_top.sv
sim/tb_board_top.sv
